/* list.f */
+incdir+verif
common/pipe_rx_pkg.sv
hw/rx_align/os_aligner.sv
hw/rx_align/ts_detector.sv
hw/power/powerdown_ctrl.sv
hw/pipe_rx_top.sv
verif/tb_pipe_rx.sv

/* verif/tb_pipe_rx_model.svh */
/*
 * Reference model of the receive path: lane swap, offset alignment, TS match, hot reset
 */

`ifndef TB_PIPE_RX_MODEL_SVH
`define TB_PIPE_RX_MODEL_SVH

// expected link words per cycle and whether their data is defined
rx_word_t     exp_q[$];
bit           known_q[$];
pipe_word_t   m_prev;
logic         m_have_prev;
logic [1:0]   m_offset;

tsdet_state_t m_state;
logic         m_hdr_ts2;
logic         m_hdr_rst;
logic         m_hit1_q;
logic         m_hit2_q;
logic         m_ts1;
logic         m_ts2;
logic         m_hot;
power_state_t exp_power;

// PHY byte 3 goes to lane 0 and the same swap turns it back
function automatic pipe_word_t swap_lanes(input pipe_word_t w);
	pipe_word_t s;
	for (int i = 0; i < 4; i++) begin
		s.data[8*i +: 8] = w.data[8*(3-i) +: 8];
		s.datak[i]       = w.datak[3-i];
	end
	return s;
endfunction

function automatic logic lane_starts(input pipe_word_t w, input int lane);
	logic [7:0] b;
	b = w.data[8*lane +: 8];
	return w.datak[lane] && (b == K_COM || b == K_SDP || b == K_SHP || b == K_LMP);
endfunction

function automatic logic header_matches(input pipe_word_t w, input logic [7:0] id);
	return w.datak == 4'h0 && w.data[31:20] == 12'h000 && w.data[15:8] == id
		&& w.data[7:0] == id;
endfunction

task automatic clear_model();
	m_have_prev = 1'b0;
	m_offset    = 2'd0;
	m_state     = TSDET_RESET;
	m_hdr_ts2   = 1'b0;
	m_hdr_rst   = 1'b0;
	m_hit1_q    = 1'b0;
	m_hit2_q    = 1'b0;
	m_ts1       = 1'b0;
	m_ts2       = 1'b0;
	m_hot       = 1'b0;
	exp_power   = P2;
	// pipeline is empty for the first three cycles
	repeat (3) begin
		exp_q.push_back('0);
		known_q.push_back(1'b1);
	end
endtask

// word entering the PHY side this cycle is seen on the link 3 cycles later
task automatic predict_link(input pipe_word_t phy, input logic valid);
	pipe_word_t  cur;
	rx_word_t    e;
	logic [63:0] d;
	logic [7:0]  k;
	cur      = swap_lanes(phy);
	e        = '0;
	e.active = valid;
	known_q.push_back(!valid || m_have_prev);
	if (valid) begin
		d = {m_prev.data, cur.data} >> (8 * (4 - m_offset));
		k = {m_prev.datak, cur.datak} >> (4 - m_offset);
		e.word.data  = d[31:0];
		e.word.datak = k[3:0];
		if (lane_starts(cur, 0)) begin
			if (lane_starts(cur, 1) && lane_starts(cur, 2) && lane_starts(cur, 3)
				&& cur.data[7:0] == K_COM)
				m_offset = 2'd0;
			else if (lane_starts(cur, 1) && lane_starts(cur, 2))
				m_offset = 2'd1;
			else if (lane_starts(cur, 1))
				m_offset = 2'd2;
			else
				m_offset = 2'd3;
		end
		m_prev      = cur;
		m_have_prev = 1'b1;
	end
	exp_q.push_back(e);
endtask

// one cycle of the training-set matcher on the word now on the link
task automatic step_detector(input rx_word_t w);
	logic [7:0] id;
	logic       com;
	logic       body;
	logic       hit1;
	logic       hit2;
	id   = m_hdr_ts2 ? TS2_ID : TS1_ID;
	com  = w.word.datak == 4'hF && w.word.data == {4{K_COM}};
	body = w.word.datak == 4'h0 && w.word.data == {4{id}};
	hit1 = m_state == TSDET_LAST && w.active && body && !m_hdr_ts2;
	hit2 = m_state == TSDET_LAST && w.active && body && m_hdr_ts2;
	m_ts1    = hit1 | m_hit1_q;
	m_ts2    = hit2 | m_hit2_q;
	m_hit1_q = hit1;
	m_hit2_q = hit2;
	if (hit2)
		m_hot = m_hdr_rst;
	if (w.active) begin
		case (m_state)
			TSDET_IDLE: if (com) m_state = TSDET_HDR;
			TSDET_HDR: begin
				m_hdr_ts2 = header_matches(w.word, TS2_ID);
				m_hdr_rst = w.word.data[16];
				m_state   = (header_matches(w.word, TS1_ID) || m_hdr_ts2) ? TSDET_BODY
					: TSDET_IDLE;
			end
			TSDET_BODY: m_state = body ? TSDET_LAST : TSDET_IDLE;
			TSDET_LAST: m_state = TSDET_IDLE;
			default: ;
		endcase
	end
	if (m_state == TSDET_RESET) begin
		m_hot   = 1'b0;
		m_state = TSDET_IDLE;
	end
	// receiver held while the PHY is powered down
	if (exp_power != P0) begin
		m_state = TSDET_RESET;
		m_hot   = 1'b0;
	end
endtask

`endif

/* verif/tb_pipe_rx.sv */
/*
 * Testbench for the PIPE receive top: random stream, training sets and power handshakes
 */

module tb_pipe_rx;
	import pipe_rx_pkg::*;

	logic         local_clk = 1'b0;
	logic         reset_n;
	pipe_word_t   phy_rx;
	logic         phy_rx_valid;
	logic [1:0]   phy_status;
	power_state_t power_req;
	logic         power_go;
	rx_word_t     link_in;
	logic         ts1_found;
	logic         ts2_found;
	logic         hot_reset;
	power_state_t power_down;
	logic         power_ack;

	// values driven on the next rising edge
	logic [1:0]   nxt_status;
	power_state_t nxt_req;
	logic         nxt_go;

	// cycles with a detector flag raised by the DUT
	int           ts1_seen;
	int           ts2_seen;

	`include "tb_pipe_rx_model.svh"

	pipe_rx_top i_pipe_rx_top (
		.local_clk    (local_clk),
		.reset_n      (reset_n),
		.phy_rx       (phy_rx),
		.phy_rx_valid (phy_rx_valid),
		.phy_status   (phy_status),
		.power_req    (power_req),
		.power_go     (power_go),
		.link_in      (link_in),
		.ts1_found    (ts1_found),
		.ts2_found    (ts2_found),
		.hot_reset    (hot_reset),
		.power_down   (power_down),
		.power_ack    (power_ack)
	);

	always #5 local_clk = ~local_clk;

	task automatic stop_on_failure(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
		input string what);
		if (got !== exp)
			stop_on_failure($sformatf("Error: time %0t: %s, got %0h, expected %0h",
				$time, what, got, exp));
	endtask

	////////////////////////////////////////////////////////////
	// one clock of drive and check against the model
	////////////////////////////////////////////////////////////

	task automatic cycle_drive(input pipe_word_t w, input logic v);
		rx_word_t e;
		bit       known;
		@(posedge local_clk);
		phy_rx       <= w;
		phy_rx_valid <= v;
		phy_status   <= nxt_status;
		power_req    <= nxt_req;
		power_go     <= nxt_go;
		predict_link(w, v);
		@(negedge local_clk);
		e     = exp_q.pop_front();
		known = known_q.pop_front();
		check_value(link_in.active, e.active, "link_in active");
		if (e.active && known)
			check_value(link_in.word, e.word, "link_in word");
		check_value(ts1_found, m_ts1, "ts1_found");
		check_value(ts2_found, m_ts2, "ts2_found");
		check_value(hot_reset, m_hot, "hot_reset");
		check_value(power_down, exp_power, "power_down");
		if (ts1_found)
			ts1_seen++;
		if (ts2_found)
			ts2_seen++;
		step_detector(e);
	endtask

	function automatic pipe_word_t random_word();
		pipe_word_t w;
		w.data  = $urandom;
		w.datak = ($urandom_range(0, 7) == 0) ? 4'($urandom) : 4'h0;
		return w;
	endfunction

	function automatic logic [7:0] pick_start();
		case ($urandom_range(0, 3))
			0: return K_COM;
			1: return K_SDP;
			2: return K_SHP;
			default: return K_LMP;
		endcase
	endfunction

	// lane 0 opens a frame and the other lanes are mixed
	function automatic pipe_word_t framing_word();
		pipe_word_t s;
		s.data[7:0] = pick_start();
		s.datak[0]  = 1'b1;
		for (int i = 1; i < 4; i++) begin
			s.datak[i]       = 1'($urandom_range(0, 1));
			s.data[8*i +: 8] = s.datak[i] ? pick_start() : 8'($urandom);
		end
		return swap_lanes(s);
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) cycle_drive(random_word(), 1'b0);
	endtask

	task automatic stream_phase(input int n);
		int r;
		repeat (n) begin
			r = $urandom_range(0, 9);
			if (r < 2)
				cycle_drive(random_word(), 1'b0);
			else if (r < 4)
				cycle_drive(framing_word(), 1'b1);
			else
				cycle_drive(random_word(), 1'b1);
		end
	endtask

	// the set follows n data bytes so that it lands at lane offset n
	task automatic send_ts(input logic is_ts2, input int n, input logic rst,
		input logic corrupt);
		logic [8:0] q[$];
		logic [7:0] id;
		pipe_word_t s;
		int         idx;
		id = is_ts2 ? TS2_ID : TS1_ID;
		repeat (n) q.push_back({1'b0, 8'($urandom)});
		repeat (4) q.push_back({1'b1, K_COM});
		q.push_back(9'h000);
		q.push_back({1'b0, 4'h0, 3'($urandom), rst});
		repeat (10) q.push_back({1'b0, id});
		if (corrupt) begin
			idx    = n + $urandom_range(0, 15);
			q[idx] = q[idx] ^ 9'(1 << $urandom_range(0, 8));
		end
		while (q.size() < 20)
			q.push_back({1'b0, 8'($urandom)});
		for (int i = 0; i < 5; i++) begin
			for (int b = 0; b < 4; b++) begin
				s.data[8*(3-b) +: 8] = q[4*i+b][7:0];
				s.datak[3-b]         = q[4*i+b][8];
			end
			cycle_drive(swap_lanes(s), 1'b1);
		end
	endtask

	////////////////////////////////////////////////////////////
	// power handshakes
	////////////////////////////////////////////////////////////

	task automatic wait_for_ack(input int expected, input string what);
		int n;
		n = 0;
		do begin
			cycle_drive(random_word(), 1'b0);
			n++;
		end while (!power_ack && n < 10);
		if (!power_ack)
			stop_on_failure({"timeout waiting for power_ack on ", what});
		check_value(n, expected, {"power_ack latency, ", what});
		cycle_drive(random_word(), 1'b0);
		check_value(power_ack, 1'b1, "power_ack second cycle");
		cycle_drive(random_word(), 1'b0);
		check_value(power_ack, 1'b0, "power_ack after pulse");
		nxt_go = 1'b0;
		cycle_drive(random_word(), 1'b0);
	endtask

	task automatic power_same();
		nxt_req = exp_power;
		nxt_go  = 1'b1;
		cycle_drive(random_word(), 1'b0);
		wait_for_ack(2, "same-state request");
	endtask

	task automatic power_change(input power_state_t target);
		nxt_req = target;
		nxt_go  = 1'b1;
		cycle_drive(random_word(), 1'b0);
		cycle_drive(random_word(), 1'b0);
		exp_power = target;
		repeat ($urandom_range(1, 6)) begin
			cycle_drive(random_word(), 1'b0);
			check_value(power_ack, 1'b0, "power_ack before PhyStatus");
		end
		nxt_status = 2'($urandom_range(1, 3));
		cycle_drive(random_word(), 1'b0);
		nxt_status = 2'b00;
		check_value(power_ack, 1'b0, "power_ack in PhyStatus cycle");
		wait_for_ack(1, "new-state request");
	endtask

	initial begin
		int kind;
		int seen1;
		int seen2;
		void'($urandom(5084));
		reset_n      = 1'b0;
		phy_rx       = '0;
		phy_rx_valid = 1'b0;
		phy_status   = 2'b00;
		power_req    = P2;
		power_go     = 1'b0;
		nxt_status   = 2'b00;
		nxt_req      = P2;
		nxt_go       = 1'b0;
		ts1_seen     = 0;
		ts2_seen     = 0;
		clear_model();
		repeat (3) @(posedge local_clk);
		reset_n <= 1'b1;

		// detector is held in P2 so this phase only exercises alignment
		stream_phase(300);
		power_change(P0);

		repeat (40) begin
			kind = $urandom_range(0, 3);
			case (kind)
				0: send_ts(1'b0, $urandom_range(0, 3), 1'b0, 1'b0);
				1: send_ts(1'b1, $urandom_range(0, 3), 1'($urandom_range(0, 1)), 1'b0);
				2: send_ts(1'($urandom_range(0, 1)), $urandom_range(0, 3), 1'b0, 1'b1);
				default: stream_phase(8);
			endcase
			idle_cycles($urandom_range(0, 3));
		end

		send_ts(1'b1, $urandom_range(0, 3), 1'b1, 1'b0);
		idle_cycles(5);
		check_value(hot_reset, 1'b1, "hot_reset after TS2 with reset bit");
		send_ts(1'b1, $urandom_range(0, 3), 1'b0, 1'b0);
		idle_cycles(5);
		check_value(hot_reset, 1'b0, "hot_reset after plain TS2");

		power_same();
		power_change(P1);
		seen1 = ts1_seen;
		seen2 = ts2_seen;
		send_ts(1'b0, $urandom_range(0, 3), 1'b0, 1'b0);
		send_ts(1'b1, $urandom_range(0, 3), 1'b1, 1'b0);
		idle_cycles(6);
		check_value(ts1_seen + ts2_seen, seen1 + seen2, "training sets while not in P0");
		check_value(ts1_seen > 0, 1'b1, "TS1 sets detected");
		check_value(ts2_seen > 0, 1'b1, "TS2 sets detected");

		$display("Result: PASSED");
		$finish;
	end

endmodule

/* hw/pipe_rx_top.sv */
/*
 * PIPE receive top: capture/align and TS detection stages plus the power manager
 */

module pipe_rx_top (
	input  logic                      local_clk,
	input  logic                      reset_n,
	input  pipe_rx_pkg::pipe_word_t    phy_rx,
	input  logic                      phy_rx_valid,
	input  logic [1:0]                phy_status,
	input  pipe_rx_pkg::power_state_t  power_req,
	input  logic                      power_go,
	output pipe_rx_pkg::rx_word_t      link_in,
	output logic                      ts1_found,
	output logic                      ts2_found,
	output logic                      hot_reset,
	output pipe_rx_pkg::power_state_t  power_down,
	output logic                      power_ack
);

	////////////////////////////////////////////////////////////
	// receive path
	////////////////////////////////////////////////////////////

	// aligned stream feeds the link and the detector alike
	os_aligner i_os_aligner (
		.local_clk    (local_clk),
		.reset_n      (reset_n),
		.phy_rx       (phy_rx),
		.phy_rx_valid (phy_rx_valid),
		.aligned      (link_in)
	);

	ts_detector i_ts_detector (
		.local_clk  (local_clk),
		.reset_n    (reset_n),
		.aligned    (link_in),
		.power_down (power_down),
		.ts1_found  (ts1_found),
		.ts2_found  (ts2_found),
		.hot_reset  (hot_reset)
	);

	////////////////////////////////////////////////////////////
	// power management
	////////////////////////////////////////////////////////////

	powerdown_ctrl i_powerdown_ctrl (
		.local_clk  (local_clk),
		.reset_n    (reset_n),
		.power_req  (power_req),
		.power_go   (power_go),
		.phy_status (phy_status),
		.power_down (power_down),
		.power_ack  (power_ack)
	);

endmodule

/* hw/power/powerdown_ctrl.sv */
/*
 * PHY power-down manager: go/ack handshake towards the link, PowerDown/PhyStatus to the PHY
 */

module powerdown_ctrl (
	input  logic                      local_clk,
	input  logic                      reset_n,
	input  pipe_rx_pkg::power_state_t  power_req,
	input  logic                      power_go,
	input  logic [1:0]                phy_status,
	output pipe_rx_pkg::power_state_t  power_down,
	output logic                      power_ack
);
	import pipe_rx_pkg::*;

	pd_state_t    pd_state;
	logic         power_go_q;
	logic         power_edge;
	power_state_t target_q;

	// request is the rising edge of go
	assign power_edge = power_go && !power_go_q;

	// requested state, held while the PHY changes over
	always_ff @(posedge local_clk) begin
		if (pd_state == PD_IDLE && power_edge)
			target_q <= power_req;
	end

	////////////////////////////////////////////////////////////
	// handshake FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge local_clk) begin
		if (!reset_n) begin
			pd_state   <= PD_RESET;
			power_go_q <= 1'b0;
			power_down <= POWER_RESET_STATE;
			power_ack  <= 1'b0;
		end else begin
			power_go_q <= power_go;
			power_ack  <= 1'b0;

			case (pd_state)
				PD_RESET: begin
					pd_state <= PD_IDLE;
				end
				PD_IDLE: begin
					if (power_edge) begin
						// nothing to change, acknowledge without the PHY
						if (power_req == power_down)
							pd_state <= PD_ACK_SAME_0;
						else
							pd_state <= PD_WAIT_PHY;
					end
				end
				PD_WAIT_PHY: begin
					power_down <= target_q;
					// PhyStatus strobe on either lane completes the change
					if (|phy_status) begin
						power_ack <= 1'b1;
						pd_state  <= PD_ACK_HOLD;
					end
				end
				PD_ACK_HOLD: begin
					power_ack <= 1'b1;
					pd_state  <= PD_IDLE;
				end
				PD_ACK_SAME_0: begin
					power_ack <= 1'b1;
					pd_state  <= PD_ACK_SAME_1;
				end
				PD_ACK_SAME_1: begin
					power_ack <= 1'b1;
					pd_state  <= PD_IDLE;
				end
				default: pd_state <= PD_RESET;
			endcase
		end
	end

	a_idle_holds_power: assert property (@(posedge local_clk) disable iff (!reset_n)
		pd_state == PD_IDLE |=> $stable(power_down));

endmodule

/* hw/rx_align/ts_detector.sv */
/*
 * Training-set detector: matches TS1/TS2 in the aligned stream and latches hot reset
 */

module ts_detector (
	input  logic                      local_clk,
	input  logic                      reset_n,
	input  pipe_rx_pkg::rx_word_t      aligned,
	input  pipe_rx_pkg::power_state_t  power_down,
	output logic                      ts1_found,
	output logic                      ts2_found,
	output logic                      hot_reset
);
	import pipe_rx_pkg::*;

	tsdet_state_t tsdet_state;

	// header contents kept for the rest of the set
	logic       hdr_is_ts2_q;
	logic       hdr_reset_q;
	logic [7:0] ts_id;

	logic com_match;
	logic hdr_ts1;
	logic hdr_ts2;
	logic body_match;
	logic ts1_hit;
	logic ts2_hit;
	logic ts1_hit_q;
	logic ts2_hit_q;

	// header has [31:20] zero, [19:16] link functions and the id in [15:0]
	function automatic logic header_is(input pipe_word_t w, input logic [7:0] id);
		return w.datak == 4'b0000 && w.data[31:20] == 12'h000 && w.data[15:0] == {id, id};
	endfunction

	assign ts_id      = hdr_is_ts2_q ? TS2_ID : TS1_ID;
	assign com_match  = aligned.word == pipe_word_t'{data: {4{K_COM}}, datak: 4'b1111};
	assign hdr_ts1    = header_is(aligned.word, TS1_ID);
	assign hdr_ts2    = header_is(aligned.word, TS2_ID);
	assign body_match = aligned.word == pipe_word_t'{data: {4{ts_id}}, datak: 4'b0000};

	// last word of a complete set
	assign ts1_hit = tsdet_state == TSDET_LAST && aligned.active && body_match && !hdr_is_ts2_q;
	assign ts2_hit = tsdet_state == TSDET_LAST && aligned.active && body_match && hdr_is_ts2_q;

	always_ff @(posedge local_clk) begin
		if (tsdet_state == TSDET_HDR && aligned.active) begin
			hdr_is_ts2_q <= hdr_ts2;
			hdr_reset_q  <= aligned.word.data[TS_RESET_BIT];
		end
	end

	always_ff @(posedge local_clk) begin
		if (!reset_n) begin
			tsdet_state <= TSDET_RESET;
			ts1_hit_q   <= 1'b0;
			ts2_hit_q   <= 1'b0;
			ts1_found   <= 1'b0;
			ts2_found   <= 1'b0;
			hot_reset   <= 1'b0;
		end else begin
			// each hit is stretched to two cycles
			ts1_hit_q <= ts1_hit;
			ts2_hit_q <= ts2_hit;
			ts1_found <= ts1_hit | ts1_hit_q;
			ts2_found <= ts2_hit | ts2_hit_q;

			// every TS2 refreshes the hot reset request
			if (ts2_hit)
				hot_reset <= hdr_reset_q;

			case (tsdet_state)
				TSDET_RESET: begin
					hot_reset   <= 1'b0;
					tsdet_state <= TSDET_IDLE;
				end
				TSDET_IDLE: begin
					if (aligned.active && com_match)
						tsdet_state <= TSDET_HDR;
				end
				TSDET_HDR: begin
					if (aligned.active)
						tsdet_state <= (hdr_ts1 || hdr_ts2) ? TSDET_BODY : TSDET_IDLE;
				end
				TSDET_BODY: begin
					if (aligned.active)
						tsdet_state <= body_match ? TSDET_LAST : TSDET_IDLE;
				end
				TSDET_LAST: begin
					if (aligned.active)
						tsdet_state <= TSDET_IDLE;
				end
				default: tsdet_state <= TSDET_RESET;
			endcase

			// receiver is only meaningful in P0
			if (power_down != P0) begin
				tsdet_state <= TSDET_RESET;
				hot_reset   <= 1'b0;
			end
		end
	end

	a_one_set_kind: assert property (@(posedge local_clk) disable iff (!reset_n)
		!(ts1_found && ts2_found));

endmodule

/* hw/rx_align/os_aligner.sv */
/*
 * Receive capture and ordered-set aligner: byte swap, framing search and
 * lane realignment of the PIPE word stream
 */

module os_aligner (
	input  logic                   local_clk,
	input  logic                   reset_n,
	input  pipe_rx_pkg::pipe_word_t phy_rx,
	input  logic                   phy_rx_valid,
	output pipe_rx_pkg::rx_word_t   aligned
);
	import pipe_rx_pkg::*;

	align_state_t align_state;

	pipe_word_t swapped;
	pipe_word_t sw_word_q;
	logic       sw_active_q;

	// previous valid word, source of the leading lanes
	pipe_word_t hold_q;
	pipe_word_t mid_word_q;
	logic       mid_active_q;
	pipe_word_t out_word_q;
	logic       out_active_q;

	logic [1:0] offset_q;
	logic [1:0] offset_next;
	logic [3:0] start_lane;
	logic       end_lane0;
	logic       framing;
	pipe_word_t mid_next;

	// PHY byte 3 lands in lane 0, bits [7:0]
	assign swapped = '{
		data:  {phy_rx.data[7:0], phy_rx.data[15:8], phy_rx.data[23:16], phy_rx.data[31:24]},
		datak: {phy_rx.datak[0], phy_rx.datak[1], phy_rx.datak[2], phy_rx.datak[3]}
	};

	////////////////////////////////////////////////////////////
	// framing detection on the swapped word
	////////////////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			start_lane[i] = is_start_sym(sw_word_q.data[8*i +: 8], sw_word_q.datak[i]);
		end
	end

	assign end_lane0 = is_end_sym(sw_word_q.data[7:0], sw_word_q.datak[0]);
	assign framing   = sw_active_q && start_lane[0];

	always_comb begin
		if (&start_lane && end_lane0)
			offset_next = 2'd0;
		else if (start_lane[1] && start_lane[2])
			offset_next = 2'd1;
		else if (start_lane[1])
			offset_next = 2'd2;
		else
			offset_next = 2'd3;
	end

	// tail of the previous word followed by the head of the current one
	always_comb begin
		case (offset_q)
			2'd0: mid_next = hold_q;
			2'd1: mid_next = '{
				data:  {hold_q.data[23:0], sw_word_q.data[31:24]},
				datak: {hold_q.datak[2:0], sw_word_q.datak[3]}
			};
			2'd2: mid_next = '{
				data:  {hold_q.data[15:0], sw_word_q.data[31:16]},
				datak: {hold_q.datak[1:0], sw_word_q.datak[3:2]}
			};
			default: mid_next = '{
				data:  {hold_q.data[7:0], sw_word_q.data[31:8]},
				datak: {hold_q.datak[0], sw_word_q.datak[3:1]}
			};
		endcase
	end

	////////////////////////////////////////////////////////////
	// pipeline registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge local_clk) begin
		sw_word_q  <= swapped;
		out_word_q <= mid_word_q;
		if (sw_active_q) begin
			hold_q     <= sw_word_q;
			mid_word_q <= mid_next;
		end
	end

	always_ff @(posedge local_clk) begin
		if (!reset_n) begin
			align_state  <= ALIGN_RESET;
			offset_q     <= 2'd0;
			sw_active_q  <= 1'b0;
			mid_active_q <= 1'b0;
			out_active_q <= 1'b0;
		end else begin
			sw_active_q  <= phy_rx_valid;
			mid_active_q <= sw_active_q;
			out_active_q <= mid_active_q;
			case (align_state)
				ALIGN_RESET: begin
					offset_q    <= 2'd0;
					align_state <= ALIGN_SEARCH;
				end
				ALIGN_SEARCH: begin
					// new offset takes effect from the word after the framing word
					if (framing)
						offset_q <= offset_next;
				end
				default: align_state <= ALIGN_RESET;
			endcase
		end
	end

	assign aligned = '{word: out_word_q, active: out_active_q};

	// the capture pipeline is three registers deep, one word per cycle
	a_valid_to_active: assert property (@(posedge local_clk) disable iff (!reset_n)
		phy_rx_valid |-> ##3 aligned.active);
	a_idle_to_inactive: assert property (@(posedge local_clk) disable iff (!reset_n)
		!phy_rx_valid |-> ##3 !aligned.active);

endmodule

/* common/pipe_rx_pkg.sv */
/*
 * PIPE receive package: word structs, K-symbol codes, state enums and power states
 */

package pipe_rx_pkg;

	////////////////////////////////////////////////////////////
	// word types
	////////////////////////////////////////////////////////////

	// one 32-bit PIPE word with its four K flags
	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  datak;
	} pipe_word_t;

	// word on the link side, qualified by active
	typedef struct packed {
		pipe_word_t word;
		logic       active;
	} rx_word_t;

	// PIPE PowerDown encoding
	typedef enum logic [1:0] {
		P0 = 2'd0,
		P1 = 2'd1,
		P2 = 2'd2,
		P3 = 2'd3
	} power_state_t;

	localparam power_state_t POWER_RESET_STATE = P2;

	////////////////////////////////////////////////////////////
	// state machines
	////////////////////////////////////////////////////////////

	typedef enum logic {
		ALIGN_RESET,
		ALIGN_SEARCH
	} align_state_t;

	typedef enum logic [2:0] {
		TSDET_RESET,
		TSDET_IDLE,
		TSDET_HDR,
		TSDET_BODY,
		TSDET_LAST
	} tsdet_state_t;

	typedef enum logic [2:0] {
		PD_RESET,
		PD_IDLE,
		PD_WAIT_PHY,
		PD_ACK_HOLD,
		PD_ACK_SAME_0,
		PD_ACK_SAME_1
	} pd_state_t;

	////////////////////////////////////////////////////////////
	// symbol codes
	////////////////////////////////////////////////////////////

	localparam logic [7:0] K_COM = 8'hBC;
	localparam logic [7:0] K_SKP = 8'h3C;
	localparam logic [7:0] K_SDP = 8'h5C;
	localparam logic [7:0] K_SHP = 8'hFB;
	localparam logic [7:0] K_END = 8'hF7;
	localparam logic [7:0] K_LMP = 8'hFE;

	// training set identifiers, and the hot reset bit in the TS header
	localparam logic [7:0] TS1_ID       = 8'h4A;
	localparam logic [7:0] TS2_ID       = 8'h45;
	localparam logic [4:0] TS_RESET_BIT = 5'd16;

	// framing symbol that may open a packet or ordered set
	function automatic logic is_start_sym(input logic [7:0] sym, input logic is_k);
		return is_k && (sym == K_COM || sym == K_SDP || sym == K_SHP || sym == K_LMP);
	endfunction

	// symbol that may close one
	function automatic logic is_end_sym(input logic [7:0] sym, input logic is_k);
		return is_k && (sym == K_END || sym == K_COM);
	endfunction

endpackage
